//--- verilog.f
+incdir+source
+incdir+testbench
source/cache_pkg.sv
source/ddr_pkg.sv
source/cache_if.sv
source/cache_array.sv
source/ddr_engine.sv
source/cache_ctrl.sv
source/cache_top.sv
testbench/tb_cache.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard source/*.sv source/*.svh testbench/*.sv testbench/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "Result: FAIL"; exit 1; \
	elif ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "Result: FAIL, simulation ended early"; exit 1; \
	fi
	@echo "Result: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_tests.svh
logic [`CACHE_DATA_W-1:0]                 model_line [`CACHE_LINE_WORDS];
logic [`CACHE_ADDR_W-`CACHE_OFFSET_W-1:0] model_tag   = '0;
logic                                     model_valid = 1'b0;
logic [31:0]                              stim_rng    = SEED;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

task automatic draw_word(output logic [`CACHE_DATA_W-1:0] w);
    stim_rng = xorshift32(stim_rng);
    w = stim_rng[`CACHE_DATA_W-1:0];
endtask

function automatic ddr_addr_t line_base(input logic [`CACHE_ADDR_W-1:0] a);
    logic [`CACHE_ADDR_W-1:0] w;
    w = a;
    w[`CACHE_OFFSET_W-1:0] = '0;
    return ddr_addr_t'(w) << `CACHE_DDR_SHIFT;
endfunction

function automatic logic [`CACHE_LINE_WORDS-1:0] model_column(
    input logic [`CACHE_OFFSET_W-1:0] cl
);
    logic [`CACHE_LINE_WORDS-1:0] v;
    for (int j = 0; j < `CACHE_LINE_WORDS; j++) begin
        v[j] = model_line[j][cl];
    end
    return v;
endfunction

// Write-allocate, so a store on a miss fills first too.
task automatic model_apply(input cache_cmd_t c, input logic [`CACHE_ADDR_W-1:0] a,
                           input logic [`CACHE_OFFSET_W-1:0] cl,
                           input logic [`CACHE_DATA_W-1:0] rw,
                           input logic [`CACHE_LINE_WORDS-1:0] cw, output logic miss);
    ddr_addr_t base;
    base = line_base(a);
    miss = !model_valid || (model_tag != a[`CACHE_ADDR_W-1:`CACHE_OFFSET_W]);
    if (miss) begin
        for (int i = 0; i < `CACHE_LINE_WORDS; i++) begin
            model_line[i] = ddr_read(word_addr(base, i));
        end
        model_tag   = a[`CACHE_ADDR_W-1:`CACHE_OFFSET_W];
        model_valid = 1'b1;
    end
    if (c == CMD_ROW_STORE) begin
        model_line[a[`CACHE_OFFSET_W-1:0]] = rw;
    end
    if (c == CMD_COL_STORE) begin
        for (int j = 0; j < `CACHE_LINE_WORDS; j++) begin
            model_line[j][cl] = cw[j];
        end
    end
endtask

// Call right after a rising edge.
task automatic issue_cmd(input cache_cmd_t c, input logic [`CACHE_ADDR_W-1:0] a,
                         input logic [`CACHE_OFFSET_W-1:0] cl,
                         input logic [`CACHE_DATA_W-1:0] rw,
                         input logic [`CACHE_LINE_WORDS-1:0] cw, input logic fl);
    int n;
    cmd_valid <= 1'b1;
    cmd       <= c;
    addr      <= a;
    col       <= cl;
    row_wdata <= rw;
    col_wdata <= cw;
    flush_en  <= fl;
    @(posedge clk);
    while (!cmd_rdy) begin
        @(posedge clk);
    end
    cmd_valid <= 1'b0;
    cmd       <= CMD_NONE;
    n = 0;
    do begin
        @(posedge clk);
        n++;
    end while (!cmd_done);
    last_latency = n;
    resp_row     = row_rdata;
    resp_col     = col_rdata;
endtask

task automatic run_access(input string name, input cache_cmd_t c,
                          input logic [`CACHE_ADDR_W-1:0] a,
                          input logic [`CACHE_OFFSET_W-1:0] cl,
                          input logic [`CACHE_DATA_W-1:0] rw,
                          input logic [`CACHE_LINE_WORDS-1:0] cw, input logic fl);
    logic miss;
    int   rd_before;
    int   wr_before;
    model_apply(c, a, cl, rw, cw, miss);
    rd_before = rd_pulses;
    wr_before = wr_acks;
    issue_cmd(c, a, cl, rw, cw, fl);
    // A fill reads 16 words and a flush writes 16.
    expect_equal(name, miss ? 32'd16 : 32'd0, 32'(rd_pulses - rd_before));
    expect_equal(name, fl ? 32'd16 : 32'd0, 32'(wr_acks - wr_before));
    if (!miss && !fl) begin
        expect_equal(name, 32'd2, 32'(last_latency));
    end
    if (c == CMD_ROW_LOAD) begin
        expect_equal(name, 32'(model_line[a[`CACHE_OFFSET_W-1:0]]), 32'(resp_row));
    end
    if (c == CMD_COL_LOAD) begin
        expect_equal(name, 32'(model_column(cl)), 32'(resp_col));
    end
endtask

task automatic reset_state();
    expect_equal("reset_state", 32'd1, 32'(cmd_rdy));
    expect_equal("reset_state", 32'd0, 32'(cmd_done));
    expect_equal("reset_state", 32'd0, 32'(ddr_rd_req));
    expect_equal("reset_state", 32'd0, 32'(ddr_wr_req));
endtask

// Model starts invalid, so this load has to fill.
task automatic miss_row_load();
    ddr_addr_t base;
    base = line_base(16'h1235);
    run_access("miss_row_load", CMD_ROW_LOAD, 16'h1235, '0, '0, '0, 1'b0);
    expect_equal("miss_row_load", 32'(base), 32'(last_rd_addr));
    expect_equal("miss_row_load", 32'(ddr_read(word_addr(base, 5))), 32'(resp_row));
endtask

task automatic hit_row_timing();
    int busy_before;
    busy_before = rd_busy_cycles;
    run_access("hit_row_timing", CMD_ROW_LOAD, 16'h123a, '0, '0, '0, 1'b0);
    expect_equal("hit_row_timing", 32'd2, 32'(last_latency));
    expect_equal("hit_row_timing", 32'(busy_before), 32'(rd_busy_cycles));
endtask

task automatic column_load();
    logic [`CACHE_OFFSET_W-1:0] cl;
    for (int k = 0; k < 3; k++) begin
        cl = `CACHE_OFFSET_W'(k * 7);
        run_access("column_load", CMD_COL_LOAD, 16'h1230 + 16'(k), cl, '0, '0, 1'b0);
    end
endtask

task automatic stores_no_flush();
    logic [`CACHE_DATA_W-1:0]     rw;
    logic [`CACHE_LINE_WORDS-1:0] cw;
    int                           busy_before;
    busy_before = wr_busy_cycles;
    draw_word(rw);
    draw_word(cw);
    run_access("stores_no_flush", CMD_ROW_STORE, 16'h1233, '0, rw, '0, 1'b0);
    run_access("stores_no_flush", CMD_COL_STORE, 16'h1230, 4'd9, '0, cw, 1'b0);
    run_access("stores_no_flush", CMD_ROW_LOAD, 16'h1233, '0, '0, '0, 1'b0);
    run_access("stores_no_flush", CMD_COL_LOAD, 16'h1230, 4'd9, '0, '0, 1'b0);
    run_access("stores_no_flush", CMD_COL_LOAD, 16'h123f, 4'd2, '0, '0, 1'b0);
    expect_equal("stores_no_flush", 32'(busy_before), 32'(wr_busy_cycles));
endtask

task automatic store_with_flush();
    logic [`CACHE_DATA_W-1:0]     rw;
    logic [`CACHE_LINE_WORDS-1:0] cw;
    ddr_addr_t                    base;
    draw_word(cw);
    run_access("store_with_flush", CMD_COL_STORE, 16'h1230, 4'd2, '0, cw, 1'b1);
    base = line_base(16'h1230);
    for (int i = 0; i < `CACHE_LINE_WORDS; i++) begin
        expect_equal("store_with_flush", 32'(model_line[i]),
                     32'(ddr_read(word_addr(base, i))));
    end
    // A new line takes a fill, the store and a flush in one command.
    draw_word(rw);
    run_access("store_with_flush", CMD_ROW_STORE, 16'h4567, '0, rw, '0, 1'b1);
    base = line_base(16'h4567);
    for (int i = 0; i < `CACHE_LINE_WORDS; i++) begin
        expect_equal("store_with_flush", 32'(model_line[i]),
                     32'(ddr_read(word_addr(base, i))));
    end
endtask

//--- testbench/tb_cache.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_macros.svh"

module tb_cache;
    import cache_pkg::*;
    import ddr_pkg::*;

    localparam logic [31:0] SEED = 32'd15;
    // Budget of 20 commands that each cost a fill plus a flush, with a margin of two.
    localparam int MAX_CMDS       = 20;
    localparam int LONGEST_CMD    = 100;
    localparam int TIMEOUT_CYCLES = MAX_CMDS * LONGEST_CMD * 2;

    logic                         clk          = 1'b0;
    logic                         rst          = 1'b0;
    logic                         cmd_valid    = 1'b0;
    cache_cmd_t                   cmd          = CMD_NONE;
    logic [`CACHE_ADDR_W-1:0]     addr         = '0;
    logic [`CACHE_OFFSET_W-1:0]   col          = '0;
    logic [`CACHE_DATA_W-1:0]     row_wdata    = '0;
    logic [`CACHE_LINE_WORDS-1:0] col_wdata    = '0;
    logic                         flush_en     = 1'b0;
    logic                         ddr_rd_valid = 1'b0;
    logic [`CACHE_DATA_W-1:0]     ddr_rd_data  = '0;
    logic                         ddr_wr_ack   = 1'b0;
    logic                         cmd_rdy;
    logic                         cmd_done;
    logic [`CACHE_DATA_W-1:0]     row_rdata;
    logic [`CACHE_LINE_WORDS-1:0] col_rdata;
    logic                         ddr_rd_req;
    ddr_addr_t                    ddr_rd_addr;
    logic                         ddr_wr_req;
    ddr_addr_t                    ddr_wr_addr;
    logic [`CACHE_DATA_W-1:0]     ddr_wr_data;

    // DDR model state.
    logic [`CACHE_DATA_W-1:0] ddr_mem [ddr_addr_t];
    int                       rd_cnt         = 0;
    int                       rd_wait        = 0;
    int                       rd_pulses      = 0;
    int                       rd_busy_cycles = 0;
    logic [31:0]              rd_rng         = SEED;
    ddr_addr_t                last_rd_addr   = '0;
    int                       wr_cnt         = 0;
    int                       wr_wait        = 0;
    int                       wr_taken       = 0;
    int                       wr_acks        = 0;
    int                       wr_busy_cycles = 0;
    logic [31:0]              wr_rng         = SEED;

    logic [`CACHE_DATA_W-1:0]     resp_row     = '0;
    logic [`CACHE_LINE_WORDS-1:0] resp_col     = '0;
    int                           last_latency = 0;
    int                           cycles       = 0;

    always #20 clk = ~clk;

    cache_top DUT (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .addr         (addr),
        .col          (col),
        .row_wdata    (row_wdata),
        .col_wdata    (col_wdata),
        .flush_en     (flush_en),
        .cmd_rdy      (cmd_rdy),
        .cmd_done     (cmd_done),
        .row_rdata    (row_rdata),
        .col_rdata    (col_rdata),
        .ddr_rd_req   (ddr_rd_req),
        .ddr_rd_addr  (ddr_rd_addr),
        .ddr_rd_valid (ddr_rd_valid),
        .ddr_rd_data  (ddr_rd_data),
        .ddr_wr_req   (ddr_wr_req),
        .ddr_wr_addr  (ddr_wr_addr),
        .ddr_wr_data  (ddr_wr_data),
        .ddr_wr_ack   (ddr_wr_ack)
    );

    function automatic logic [`CACHE_DATA_W-1:0] mem_pattern(input ddr_addr_t a);
        return 16'(a[15:0] * 16'h9e37) ^ a[27:12];
    endfunction

    function automatic ddr_addr_t word_addr(input ddr_addr_t base, input int i);
        return base + (ddr_addr_t'(i) << `CACHE_DDR_SHIFT);
    endfunction

    // Untouched locations read as the fill pattern.
    function automatic logic [`CACHE_DATA_W-1:0] ddr_read(input ddr_addr_t a);
        if (ddr_mem.exists(a)) begin
            return ddr_mem[a];
        end
        return mem_pattern(a);
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    `include "tb_tests.svh"

    // DDR read model gives one word per valid after 0 to 2 idle cycles.
    always @(posedge clk) begin
        if (!rst) begin
            ddr_rd_valid <= 1'b0;
            rd_cnt       <= 0;
            rd_wait      <= 0;
        end else if (ddr_rd_req) begin
            rd_busy_cycles <= rd_busy_cycles + 1;
            last_rd_addr   <= ddr_rd_addr;
            if (ddr_rd_valid) begin
                rd_pulses <= rd_pulses + 1;
            end
            if (rd_cnt < `CACHE_LINE_WORDS && rd_wait == 0) begin
                ddr_rd_valid <= 1'b1;
                ddr_rd_data  <= ddr_read(word_addr(ddr_rd_addr, rd_cnt));
                rd_cnt       <= rd_cnt + 1;
                rd_rng       <= xorshift32(rd_rng);
                rd_wait      <= int'(rd_rng % 3);
            end else begin
                ddr_rd_valid <= 1'b0;
                if (rd_wait != 0) begin
                    rd_wait <= rd_wait - 1;
                end
            end
        end else begin
            ddr_rd_valid <= 1'b0;
            rd_cnt       <= 0;
        end
    end

    // DDR write model stores a word at the edge that sees its ack.
    always @(posedge clk) begin
        if (!rst) begin
            ddr_wr_ack <= 1'b0;
            wr_cnt     <= 0;
            wr_wait    <= 0;
        end else if (ddr_wr_req) begin
            wr_busy_cycles <= wr_busy_cycles + 1;
            wr_taken = wr_cnt + (ddr_wr_ack ? 1 : 0);
            if (ddr_wr_ack) begin
                ddr_mem[word_addr(ddr_wr_addr, wr_cnt)] = ddr_wr_data;
                wr_acks <= wr_acks + 1;
            end
            wr_cnt <= wr_taken;
            if (wr_taken < `CACHE_LINE_WORDS && wr_wait == 0) begin
                ddr_wr_ack <= 1'b1;
                wr_rng     <= xorshift32(wr_rng);
                wr_wait    <= int'(wr_rng % 3);
            end else begin
                ddr_wr_ack <= 1'b0;
                if (wr_wait != 0) begin
                    wr_wait <= wr_wait - 1;
                end
            end
        end else begin
            ddr_wr_ack <= 1'b0;
            wr_cnt     <= 0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        reset_state();
        miss_row_load();
        hit_row_timing();
        column_load();
        stores_no_flush();
        store_with_flush();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/cache_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_macros.svh"

module cache_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cmd_valid,
    input  cache_pkg::cache_cmd_t        cmd,
    input  logic [`CACHE_ADDR_W-1:0]     addr,
    input  logic [`CACHE_OFFSET_W-1:0]   col,
    input  logic [`CACHE_DATA_W-1:0]     row_wdata,
    input  logic [`CACHE_LINE_WORDS-1:0] col_wdata,
    input  logic                         flush_en,
    output logic                         cmd_rdy,
    output logic                         cmd_done,
    output logic [`CACHE_DATA_W-1:0]     row_rdata,
    output logic [`CACHE_LINE_WORDS-1:0] col_rdata,
    output logic                         ddr_rd_req,
    output ddr_pkg::ddr_addr_t           ddr_rd_addr,
    input  logic                         ddr_rd_valid,
    input  logic [`CACHE_DATA_W-1:0]     ddr_rd_data,
    output logic                         ddr_wr_req,
    output ddr_pkg::ddr_addr_t           ddr_wr_addr,
    output logic [`CACHE_DATA_W-1:0]     ddr_wr_data,
    input  logic                         ddr_wr_ack
);
    import cache_pkg::*;

    cache_addr_u addr_u;

    array_if arr_bus ();
    line_if  line_bus ();
    xfer_if  xfer_bus ();

    assign addr_u = cache_addr_u'(addr);

    cache_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .addr      (addr_u),
        .col       (col),
        .row_wdata (row_wdata),
        .col_wdata (col_wdata),
        .flush_en  (flush_en),
        .cmd_rdy   (cmd_rdy),
        .cmd_done  (cmd_done),
        .row_rdata (row_rdata),
        .col_rdata (col_rdata),
        .arr       (arr_bus.ctrl),
        .xfer      (xfer_bus.ctrl)
    );

    cache_array u_array (
        .clk  (clk),
        .rst  (rst),
        .cpu  (arr_bus.array),
        .line (line_bus.array)
    );

    ddr_engine u_engine (
        .clk          (clk),
        .rst          (rst),
        .xfer         (xfer_bus.engine),
        .line         (line_bus.engine),
        .ddr_rd_req   (ddr_rd_req),
        .ddr_rd_addr  (ddr_rd_addr),
        .ddr_rd_valid (ddr_rd_valid),
        .ddr_rd_data  (ddr_rd_data),
        .ddr_wr_req   (ddr_wr_req),
        .ddr_wr_addr  (ddr_wr_addr),
        .ddr_wr_data  (ddr_wr_data),
        .ddr_wr_ack   (ddr_wr_ack)
    );

endmodule

`default_nettype wire

//--- source/cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_macros.svh"

module cache_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cmd_valid,
    input  cache_pkg::cache_cmd_t        cmd,
    input  cache_pkg::cache_addr_u       addr,
    input  logic [`CACHE_OFFSET_W-1:0]   col,
    input  logic [`CACHE_DATA_W-1:0]     row_wdata,
    input  logic [`CACHE_LINE_WORDS-1:0] col_wdata,
    input  logic                         flush_en,
    output logic                         cmd_rdy,
    output logic                         cmd_done,
    output logic [`CACHE_DATA_W-1:0]     row_rdata,
    output logic [`CACHE_LINE_WORDS-1:0] col_rdata,
    array_if.ctrl                        arr,
    xfer_if.ctrl                         xfer
);
    import cache_pkg::*;
    import ddr_pkg::*;

    ctrl_state_t                              state;
    ctrl_state_t                              state_next;
    cache_cmd_t                               cmd_q;
    cache_addr_u                              addr_q;
    logic [`CACHE_OFFSET_W-1:0]               col_q;
    logic [`CACHE_DATA_W-1:0]                 row_wdata_q;
    logic [`CACHE_LINE_WORDS-1:0]             col_wdata_q;
    logic                                     flush_q;
    logic [`CACHE_ADDR_W-`CACHE_OFFSET_W-1:0] tag_q;
    logic                                     tag_valid;
    logic                                     hit;
    logic                                     miss;
    logic                                     is_store;
    logic                                     do_access;
    logic                                     do_flush;

    assign cmd_rdy   = (state == ST_IDLE);
    assign hit       = tag_valid && (tag_q == addr_q.f.tag);
    assign miss      = (cmd_q != CMD_NONE) && !hit;
    assign is_store  = (cmd_q == CMD_ROW_STORE) || (cmd_q == CMD_COL_STORE);
    // Hits are served straight from lookup.
    assign do_access = ((state == ST_LOOKUP) && !miss) || (state == ST_ACCESS);
    assign do_flush  = do_access && is_store && flush_q;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (cmd_valid) begin
                    state_next = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (miss) begin
                    state_next = ST_FILL_WAIT;
                end else if (do_flush) begin
                    state_next = ST_FLUSH_WAIT;
                end else begin
                    state_next = ST_RESPOND;
                end
            end
            ST_FILL_WAIT: begin
                if (xfer.done) begin
                    state_next = ST_ACCESS;
                end
            end
            ST_ACCESS: begin
                state_next = do_flush ? ST_FLUSH_WAIT : ST_RESPOND;
            end
            ST_FLUSH_WAIT: begin
                if (xfer.done) begin
                    state_next = ST_RESPOND;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= ST_IDLE;
            cmd_done  <= 1'b0;
            tag_q     <= '0;
            tag_valid <= 1'b0;
        end else begin
            state    <= state_next;
            cmd_done <= (state_next == ST_RESPOND);
            // Line now holds the new tag.
            if ((state == ST_FILL_WAIT) && xfer.done) begin
                tag_q     <= addr_q.f.tag;
                tag_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_rdy) begin
            cmd_q       <= cmd;
            addr_q      <= addr;
            col_q       <= col;
            row_wdata_q <= row_wdata;
            col_wdata_q <= col_wdata;
            flush_q     <= flush_en;
        end
        if (do_access && (cmd_q == CMD_ROW_LOAD)) begin
            row_rdata <= arr.row_rdata;
        end
        if (do_access && (cmd_q == CMD_COL_LOAD)) begin
            col_rdata <= arr.col_rdata;
        end
    end

    assign arr.row_index = addr_q.f.offset;
    assign arr.row_wdata = row_wdata_q;
    assign arr.row_we    = do_access && (cmd_q == CMD_ROW_STORE);
    assign arr.col_index = col_q;
    assign arr.col_wdata = col_wdata_q;
    assign arr.col_we    = do_access && (cmd_q == CMD_COL_STORE);

    // Fill on a miss, flush after the store lands.
    assign xfer.start = ((state == ST_LOOKUP) && miss) || do_flush;
    assign xfer.kind  = miss ? BURST_FILL : BURST_FLUSH;
    assign xfer.base  = {addr_q.f.tag, {`CACHE_OFFSET_W{1'b0}}};

    // A burst ends only while the controller waits for it.
    a_done_in_wait: assert property (
        @(posedge clk) disable iff (!rst)
        xfer.done |-> (state == ST_FILL_WAIT) || (state == ST_FLUSH_WAIT)
    );

endmodule

`default_nettype wire

//--- source/ddr_engine.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_macros.svh"

module ddr_engine (
    input  logic                     clk,
    input  logic                     rst,
    xfer_if.engine                   xfer,
    line_if.engine                   line,
    output logic                     ddr_rd_req,
    output ddr_pkg::ddr_addr_t       ddr_rd_addr,
    input  logic                     ddr_rd_valid,
    input  logic [`CACHE_DATA_W-1:0] ddr_rd_data,
    output logic                     ddr_wr_req,
    output ddr_pkg::ddr_addr_t       ddr_wr_addr,
    output logic [`CACHE_DATA_W-1:0] ddr_wr_data,
    input  logic                     ddr_wr_ack
);
    import ddr_pkg::*;

    localparam int CNT_W = `CACHE_OFFSET_W + 1;

    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] cnt_next;
    logic             beat;
    logic             last;
    ddr_addr_t        base_addr;

    // A word moves on each valid in a fill, each ack in a flush.
    assign beat     = (ddr_rd_req && ddr_rd_valid) || (ddr_wr_req && ddr_wr_ack);
    assign cnt_next = cnt + CNT_W'(1);
    assign last     = beat && (cnt_next == CNT_W'(`CACHE_LINE_WORDS));

    // The two request flags are the idle/fill/flush state.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ddr_rd_req <= 1'b0;
            ddr_wr_req <= 1'b0;
            cnt        <= '0;
            xfer.done  <= 1'b0;
        end else begin
            xfer.done <= last;
            if (xfer.start) begin
                ddr_rd_req <= (xfer.kind == BURST_FILL);
                ddr_wr_req <= (xfer.kind == BURST_FLUSH);
                cnt        <= '0;
            end else if (last) begin
                ddr_rd_req <= 1'b0;
                ddr_wr_req <= 1'b0;
                cnt        <= '0;
            end else if (beat) begin
                cnt <= cnt_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer.start) begin
            base_addr <= ddr_addr_t'(xfer.base.word) << `CACHE_DDR_SHIFT;
        end
    end

    // Memory counts the words, so the address stays at the base.
    assign ddr_rd_addr = base_addr;
    assign ddr_wr_addr = base_addr;

    assign line.word_index = cnt[`CACHE_OFFSET_W-1:0];
    assign line.word_wdata = ddr_rd_data;
    assign line.word_we    = ddr_rd_req && ddr_rd_valid;
    assign ddr_wr_data     = line.word_rdata;

    // A new burst starts only while no request is open.
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!rst)
        xfer.start |-> !ddr_rd_req && !ddr_wr_req
    );

endmodule

`default_nettype wire

//--- source/cache_array.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_macros.svh"

module cache_array (
    input  logic    clk,
    input  logic    rst,
    array_if.array  cpu,
    line_if.array   line
);

    logic [`CACHE_DATA_W-1:0] mem [`CACHE_LINE_WORDS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `CACHE_LINE_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (line.word_we) begin
                mem[line.word_index] <= line.word_wdata;
            end
            if (cpu.row_we) begin
                mem[cpu.row_index] <= cpu.row_wdata;
            end
            // One bit into every word.
            if (cpu.col_we) begin
                for (int j = 0; j < `CACHE_LINE_WORDS; j++) begin
                    mem[j][cpu.col_index] <= cpu.col_wdata[j];
                end
            end
        end
    end

    assign cpu.row_rdata   = mem[cpu.row_index];
    assign line.word_rdata = mem[line.word_index];

    always_comb begin
        for (int j = 0; j < `CACHE_LINE_WORDS; j++) begin
            cpu.col_rdata[j] = mem[j][cpu.col_index];
        end
    end

    // Controller must stay off the line while a burst runs.
    a_one_port: assert property (
        @(posedge clk) disable iff (!rst)
        !((cpu.row_we || cpu.col_we) && line.word_we)
    );

endmodule

`default_nettype wire

//--- source/cache_if.sv
`timescale 1ns/1ns
`default_nettype none
`include "cache_macros.svh"

// Row and column access to the line.
interface array_if;
    logic [`CACHE_OFFSET_W-1:0]   row_index;
    logic [`CACHE_DATA_W-1:0]     row_wdata;
    logic                         row_we;
    logic [`CACHE_DATA_W-1:0]     row_rdata;
    logic [`CACHE_OFFSET_W-1:0]   col_index;
    logic [`CACHE_LINE_WORDS-1:0] col_wdata;
    logic                         col_we;
    logic [`CACHE_LINE_WORDS-1:0] col_rdata;

    modport ctrl (
        output row_index, row_wdata, row_we, col_index, col_wdata, col_we,
        input  row_rdata, col_rdata
    );
    modport array (
        input  row_index, row_wdata, row_we, col_index, col_wdata, col_we,
        output row_rdata, col_rdata
    );
endinterface

// Word port used by the burst engine.
interface line_if;
    logic [`CACHE_OFFSET_W-1:0] word_index;
    logic [`CACHE_DATA_W-1:0]   word_wdata;
    logic                       word_we;
    logic [`CACHE_DATA_W-1:0]   word_rdata;

    modport engine (output word_index, word_wdata, word_we, input word_rdata);
    modport array (input word_index, word_wdata, word_we, output word_rdata);
endinterface

// Burst request from the controller.
interface xfer_if;
    import cache_pkg::*;
    import ddr_pkg::*;

    logic        start;
    ddr_burst_t  kind;
    cache_addr_u base;
    logic        done;

    modport ctrl (output start, kind, base, input done);
    modport engine (input start, kind, base, output done);
endinterface

`default_nettype wire

//--- source/ddr_pkg.sv
`default_nettype none
`include "cache_macros.svh"

package ddr_pkg;

    typedef logic [`CACHE_DDR_ADDR_W-1:0] ddr_addr_t;

    // Direction of a line burst.
    typedef enum logic {
        BURST_FILL  = 1'b0,
        BURST_FLUSH = 1'b1
    } ddr_burst_t;

endpackage

`default_nettype wire

//--- source/cache_pkg.sv
`default_nettype none
`include "cache_macros.svh"

package cache_pkg;

    // Client commands.
    typedef enum logic [2:0] {
        CMD_NONE      = 3'd0,
        CMD_ROW_LOAD  = 3'd1,
        CMD_ROW_STORE = 3'd2,
        CMD_COL_LOAD  = 3'd3,
        CMD_COL_STORE = 3'd4
    } cache_cmd_t;

    // Word address, or tag plus offset within the line.
    typedef union packed {
        logic [`CACHE_ADDR_W-1:0] word;
        struct packed {
            logic [`CACHE_ADDR_W-`CACHE_OFFSET_W-1:0] tag;
            logic [`CACHE_OFFSET_W-1:0]               offset;
        } f;
    } cache_addr_u;

    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_LOOKUP     = 3'd1,
        ST_FILL_WAIT  = 3'd2,
        ST_ACCESS     = 3'd3,
        ST_FLUSH_WAIT = 3'd4,
        ST_RESPOND    = 3'd5
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Word and line geometry.
`define CACHE_DATA_W       16
`define CACHE_LINE_WORDS   16
`define CACHE_OFFSET_W     4

// Client word address.
`define CACHE_ADDR_W       16

// DDR side addressing.
`define CACHE_DDR_ADDR_W   28

// Word address to DDR address.
`define CACHE_DDR_SHIFT    3

`endif
